// ==== common/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address into physical memory
`define MEM_ADDR_WIDTH 32

// one cache line, as seen by both caches
`define MEM_LINE_WIDTH 256

// one beat on the burst bus
`define MEM_BEAT_WIDTH 64

// beats per line transfer
`define MEM_BURST_LEN 4

`endif

// ==== common/mem_types.sv ====
`include "mem_consts.svh"

package mem_types;

    // line aligned byte address, low 5 bits zero
    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MEM_LINE_WIDTH-1:0] line_t;
    typedef logic [`MEM_BEAT_WIDTH-1:0] beat_t;
    // counts beats within one burst
    typedef logic [$clog2(`MEM_BURST_LEN)-1:0] beat_idx_t;

    // arbiter grant states
    typedef enum logic [1:0] {
        arb_none,
        arb_instr,
        arb_data,
        arb_both
    } arb_state_t;

    // adaptor burst states
    typedef enum logic [1:0] {
        ad_idle,
        ad_read,
        ad_write,
        ad_done
    } adaptor_state_t;

endpackage : mem_types

// ==== arbiter/arbiter.sv ====
`timescale 1ns/1ns

module arbiter
import mem_types::*;
(
    input  logic  clk,
    input  logic  rst,

    // instruction cache port
    input  addr_t instr_address,
    input  line_t instr_wdata,
    input  logic  instr_read,
    input  logic  instr_write,
    output line_t instr_rdata,
    output logic  instr_resp,

    // data cache port
    input  addr_t data_address,
    input  line_t data_wdata,
    input  logic  data_read,
    input  logic  data_write,
    output line_t data_rdata,
    output logic  data_resp,

    // shared line port toward the adaptor
    output addr_t line_address,
    output line_t line_wdata,
    output logic  line_read,
    output logic  line_write,
    input  line_t line_rdata,
    input  logic  line_resp
);

    arb_state_t state;
    arb_state_t next_state;

    // a port is active on either strobe
    logic instr_req;
    logic data_req;

    assign instr_req = instr_read || instr_write;
    assign data_req  = data_read || data_write;

    // route the granted port onto the line port
    always_comb begin
        // idle defaults, nothing reaches memory
        line_address = '0;
        line_wdata   = '0;
        line_read    = 1'b0;
        line_write   = 1'b0;
        instr_rdata  = '0;
        instr_resp   = 1'b0;
        data_rdata   = '0;
        data_resp    = 1'b0;
        unique case (state)
            arb_none: begin
                // hold everything low
            end
            // tie is served instruction side first
            arb_instr, arb_both: begin
                line_address = instr_address;
                line_wdata   = instr_wdata;
                line_read    = instr_read;
                line_write   = instr_write;
                instr_rdata  = line_rdata;
                instr_resp   = line_resp;
            end
            arb_data: begin
                line_address = data_address;
                line_wdata   = data_wdata;
                line_read    = data_read;
                line_write   = data_write;
                data_rdata   = line_rdata;
                data_resp    = line_resp;
            end
            default: begin
                // unreachable with a 2-bit enum
            end
        endcase
    end

    // grant transitions
    always_comb begin
        // hold by default
        next_state = state;
        unique case (state)
            arb_none: begin
                if (instr_req && data_req) begin
                    next_state = arb_both;
                end else if (instr_req) begin
                    next_state = arb_instr;
                end else if (data_req) begin
                    next_state = arb_data;
                end
            end
            arb_instr, arb_data: begin
                // grant ends with the line response
                if (line_resp) begin
                    next_state = arb_none;
                end
            end
            arb_both: begin
                // hand over only if data still wants memory
                if (line_resp) begin
                    next_state = data_req ? arb_data : arb_none;
                end
            end
            default: begin
                next_state = arb_none;
            end
        endcase
    end

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_none;
        end else begin
            state <= next_state;
        end
    end

endmodule : arbiter

// ==== cacheline_adaptor/cacheline_adaptor.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module cacheline_adaptor
import mem_types::*;
(
    input  logic  clk,
    input  logic  rst,

    // line port from the arbiter
    input  addr_t line_address,
    input  line_t line_wdata,
    input  logic  line_read,
    input  logic  line_write,
    output line_t line_rdata,
    output logic  line_resp,

    // burst bus toward memory
    output addr_t burst_address,
    output beat_t burst_wdata,
    output logic  burst_read,
    output logic  burst_write,
    input  beat_t burst_rdata,
    input  logic  burst_resp
);

    adaptor_state_t state;
    adaptor_state_t next_state;

    // beat position within the current burst
    beat_idx_t beat_idx;

    // latched request, line port may move after resp
    addr_t addr_q;
    // write line on a write, gathered beats on a read
    line_t line_q;

    // one beat accepted this cycle
    logic beat_ok;
    // fourth beat accepted this cycle
    logic last_beat;
    // new line request taken from idle
    logic start;

    assign start     = (state == ad_idle) && (line_read || line_write);
    assign beat_ok   = burst_resp && ((state == ad_read) || (state == ad_write));
    assign last_beat = beat_ok && (beat_idx == beat_idx_t'(`MEM_BURST_LEN - 1));

    // burst bus drive
    assign burst_read    = (state == ad_read);
    assign burst_write   = (state == ad_write);
    assign burst_address = addr_q;
    // current beat, low 64 bits first
    assign burst_wdata   = line_q[beat_idx * `MEM_BEAT_WIDTH +: `MEM_BEAT_WIDTH];

    // line side return, stable through ad_done
    assign line_rdata = line_q;
    assign line_resp  = (state == ad_done);

    always_comb begin
        next_state = state;
        unique case (state)
            ad_idle: begin
                // read wins if both are ever seen
                if (line_read) begin
                    next_state = ad_read;
                end else if (line_write) begin
                    next_state = ad_write;
                end
            end
            ad_read, ad_write: begin
                if (last_beat) begin
                    next_state = ad_done;
                end
            end
            ad_done: begin
                // single cycle of line_resp
                next_state = ad_idle;
            end
            default: begin
                next_state = ad_idle;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ad_idle;
            beat_idx <= '0;
        end else begin
            state <= next_state;
            if (start) begin
                beat_idx <= '0;
            end else if (beat_ok) begin
                // wraps back to 0 after the last beat
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    // request capture and read gather
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= line_address;
            line_q <= line_wdata;
        end else if ((state == ad_read) && burst_resp) begin
            // shift in from the top, beat 0 ends up in bits 63:0
            line_q <= {burst_rdata, line_q[`MEM_LINE_WIDTH-1:`MEM_BEAT_WIDTH]};
        end
    end

endmodule : cacheline_adaptor

// ==== rtl/mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem
import mem_types::*;
(
    input  logic  clk,
    input  logic  rst,

    // instruction cache
    input  addr_t instr_address,
    input  line_t instr_wdata,
    output line_t instr_rdata,
    input  logic  instr_read,
    input  logic  instr_write,
    output logic  instr_resp,

    // data cache
    input  addr_t data_address,
    input  line_t data_wdata,
    output line_t data_rdata,
    input  logic  data_read,
    input  logic  data_write,
    output logic  data_resp,

    // burst memory bus
    output addr_t burst_address,
    output beat_t burst_wdata,
    input  beat_t burst_rdata,
    output logic  burst_read,
    output logic  burst_write,
    input  logic  burst_resp
);

    // line port between arbiter and adaptor
    addr_t line_address;
    line_t line_wdata;
    line_t line_rdata;
    logic  line_read;
    logic  line_write;
    logic  line_resp;

    // picks one cache port per line transfer
    arbiter i_arbiter (
        .clk           (clk),
        .rst           (rst),
        .instr_address (instr_address),
        .instr_wdata   (instr_wdata),
        .instr_read    (instr_read),
        .instr_write   (instr_write),
        .instr_rdata   (instr_rdata),
        .instr_resp    (instr_resp),
        .data_address  (data_address),
        .data_wdata    (data_wdata),
        .data_read     (data_read),
        .data_write    (data_write),
        .data_rdata    (data_rdata),
        .data_resp     (data_resp),
        .line_address  (line_address),
        .line_wdata    (line_wdata),
        .line_read     (line_read),
        .line_write    (line_write),
        .line_rdata    (line_rdata),
        .line_resp     (line_resp)
    );

    // line to four-beat burst conversion
    cacheline_adaptor i_cacheline_adaptor (
        .clk           (clk),
        .rst           (rst),
        .line_address  (line_address),
        .line_wdata    (line_wdata),
        .line_read     (line_read),
        .line_write    (line_write),
        .line_rdata    (line_rdata),
        .line_resp     (line_resp),
        .burst_address (burst_address),
        .burst_wdata   (burst_wdata),
        .burst_read    (burst_read),
        .burst_write   (burst_write),
        .burst_rdata   (burst_rdata),
        .burst_resp    (burst_resp)
    );

endmodule : mem_subsystem

// ==== bench/mem_checker.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_checker
import mem_types::*;
(
    input  logic  clk,
    input  logic  rst,
    input  addr_t instr_address,
    input  line_t instr_wdata,
    input  line_t instr_rdata,
    input  logic  instr_read,
    input  logic  instr_write,
    input  logic  instr_resp,
    input  addr_t data_address,
    input  line_t data_wdata,
    input  line_t data_rdata,
    input  logic  data_read,
    input  logic  data_write,
    input  logic  data_resp,
    input  addr_t burst_address,
    input  beat_t burst_wdata,
    input  logic  burst_read,
    input  logic  burst_write,
    input  logic  burst_resp,
    output int    data_errors,
    output int    proto_errors
);

    // shadow of memory as the caches should see it
    line_t shadow [addr_t];
    // write beats gathered off the burst bus
    line_t wr_line;
    addr_t beat_addr;
    int    beat_cnt;
    int    cycle;
    // cycle in which each pending request started
    int    instr_start;
    int    data_start;
    logic  instr_busy;
    logic  data_busy;
    logic  req_seen;

    initial begin
        data_errors  = 0;
        proto_errors = 0;
    end

    // untouched lines hold their address in every word
    function automatic line_t expected_line(input addr_t addr);
        return shadow.exists(addr) ? shadow[addr] : {8{addr}};
    endfunction

    // one transfer finished on a cache port
    task automatic finish_transfer(input string port, input logic rd, input addr_t addr,
                                   input line_t wdata, input line_t rdata);
        if (beat_cnt != `MEM_BURST_LEN || beat_addr != addr) begin
            proto_errors++;
            $display("%s transfer at %0t did not run one four-beat burst at its address",
                     port, $time);
        end
        if (rd && rdata !== expected_line(addr)) begin
            data_errors++;
            $display("Mismatch at %0t: %s read of %h returned %h, expected %h",
                     $time, port, addr, rdata, expected_line(addr));
        end
        if (!rd && wr_line !== wdata) begin
            data_errors++;
            $display("Mismatch at %0t: %s write of %h sent beats %h, expected %h",
                     $time, port, addr, wr_line, wdata);
        end
        // shadow takes the write once its resp is seen
        if (!rd) begin
            shadow[addr] = wdata;
        end
        beat_cnt = 0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            beat_cnt   = 0;
            cycle      = 0;
            instr_busy = 1'b0;
            data_busy  = 1'b0;
            req_seen   = 1'b0;
        end else begin
            cycle++;
            // nothing moves before the first request
            if (!req_seen && (instr_resp !== 1'b0 || data_resp !== 1'b0
                    || burst_read !== 1'b0 || burst_write !== 1'b0)) begin
                proto_errors++;
                $display("port activity at %0t before any request was made", $time);
            end
            if (!instr_busy && (instr_read || instr_write)) begin
                instr_busy  = 1'b1;
                instr_start = cycle;
                req_seen    = 1'b1;
            end
            if (!data_busy && (data_read || data_write)) begin
                data_busy  = 1'b1;
                data_start = cycle;
                req_seen   = 1'b1;
            end
            // accepted beats fill the line from the low beat up
            if (burst_resp && (burst_read || burst_write)) begin
                if (burst_write && beat_cnt < `MEM_BURST_LEN) begin
                    wr_line[beat_cnt*`MEM_BEAT_WIDTH +: `MEM_BEAT_WIDTH] = burst_wdata;
                end
                beat_addr = burst_address;
                beat_cnt++;
            end
            if ((instr_resp && !instr_busy) || (data_resp && !data_busy)
                    || (instr_resp && data_resp)) begin
                proto_errors++;
                $display("unexpected response at %0t on a port with no request", $time);
            end
            if (instr_resp && instr_busy) begin
                finish_transfer("instr", instr_read, instr_address, instr_wdata, instr_rdata);
                instr_busy = 1'b0;
            end
            // data loses any tie
            if (data_resp && data_busy) begin
                if (instr_busy && instr_start <= data_start) begin
                    proto_errors++;
                    $display("data port served at %0t ahead of the instr port", $time);
                end
                finish_transfer("data", data_read, data_address, data_wdata, data_rdata);
                data_busy = 1'b0;
            end
        end
    end

endmodule : mem_checker

// ==== bench/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module tb_mem_subsystem
import mem_types::*;
();

    localparam int NUM_STEPS = 12;
    localparam int OP_NONE   = 0;
    localparam int OP_READ   = 1;
    localparam int OP_WRITE  = 2;
    // two transfers per step at up to 20 cycles each, plus reset and idle margin
    localparam int TIMEOUT_CYCLES = NUM_STEPS * 2 * 20 + 60;

    logic  clk;
    logic  rst;
    addr_t instr_address;
    line_t instr_wdata;
    line_t instr_rdata;
    logic  instr_read;
    logic  instr_write;
    logic  instr_resp;
    addr_t data_address;
    line_t data_wdata;
    line_t data_rdata;
    logic  data_read;
    logic  data_write;
    logic  data_resp;
    addr_t burst_address;
    beat_t burst_wdata;
    beat_t burst_rdata;
    logic  burst_read;
    logic  burst_write;
    logic  burst_resp;
    int    data_errors;
    int    proto_errors;

    // stimulus table, one row per step
    int    step_iop [NUM_STEPS];
    addr_t step_iaddr [NUM_STEPS];
    line_t step_iwdata [NUM_STEPS];
    int    step_dop [NUM_STEPS];
    addr_t step_daddr [NUM_STEPS];
    line_t step_dwdata [NUM_STEPS];

    // burst memory model, keyed by line address
    line_t       mem_model [addr_t];
    logic [31:0] rng_state;
    int          cycles = 0;

    mem_subsystem i_mem_subsystem (.*);

    mem_checker i_mem_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // every word tagged, low byte gives its position in the line
    function automatic line_t make_line(input logic [23:0] tag);
        line_t l;
        for (int j = 0; j < 8; j++) begin
            l[j*32 +: 32] = {tag, 8'(j)};
        end
        return l;
    endfunction

    task automatic set_step(input int k, input int iop, input addr_t iaddr, input line_t iwdata,
                            input int dop, input addr_t daddr, input line_t dwdata);
        step_iop[k]    = iop;
        step_iaddr[k]  = iaddr;
        step_iwdata[k] = iwdata;
        step_dop[k]    = dop;
        step_daddr[k]  = daddr;
        step_dwdata[k] = dwdata;
    endtask

    task automatic load_table();
        set_step(0, OP_READ, 32'h100, '0, OP_NONE, 32'h0, '0);
        set_step(1, OP_NONE, 32'h0, '0, OP_READ, 32'h200, '0);
        set_step(2, OP_NONE, 32'h0, '0, OP_WRITE, 32'h200, make_line(24'ha00200));
        set_step(3, OP_NONE, 32'h0, '0, OP_READ, 32'h200, '0);
        set_step(4, OP_READ, 32'h200, '0, OP_NONE, 32'h0, '0);
        // ties from here on, instruction side first
        set_step(5, OP_READ, 32'h300, '0, OP_READ, 32'h400, '0);
        set_step(6, OP_READ, 32'h500, '0, OP_WRITE, 32'h600, make_line(24'hb00600));
        set_step(7, OP_READ, 32'h600, '0, OP_READ, 32'h600, '0);
        set_step(8, OP_WRITE, 32'h700, make_line(24'hc00700), OP_READ, 32'h700, '0);
        set_step(9, OP_READ, 32'h800, '0, OP_WRITE, 32'h100, make_line(24'hd00100));
        set_step(10, OP_READ, 32'h100, '0, OP_READ, 32'h700, '0);
        // instr must still see the old line here
        set_step(11, OP_READ, 32'h900, '0, OP_WRITE, 32'h900, make_line(24'he00900));
    endtask

    // hold the request until its own resp, then drop it
    task automatic drive_instr(input int op, input addr_t addr, input line_t wdata);
        if (op != OP_NONE) begin
            instr_address = addr;
            instr_wdata   = wdata;
            instr_read    = (op == OP_READ);
            instr_write   = (op == OP_WRITE);
            @(negedge clk);
            while (!instr_resp) @(negedge clk);
            @(posedge clk);
            #1;
            instr_read  = 1'b0;
            instr_write = 1'b0;
        end
    endtask

    task automatic drive_data(input int op, input addr_t addr, input line_t wdata);
        if (op != OP_NONE) begin
            data_address = addr;
            data_wdata   = wdata;
            data_read    = (op == OP_READ);
            data_write   = (op == OP_WRITE);
            @(negedge clk);
            while (!data_resp) @(negedge clk);
            @(posedge clk);
            #1;
            data_read  = 1'b0;
            data_write = 1'b0;
        end
    endtask

    // one four-beat burst with random gaps before each beat
    task automatic serve_burst();
        addr_t addr;
        line_t cur_line;
        logic  is_write;
        int    gaps;
        addr     = burst_address;
        is_write = burst_write;
        cur_line = mem_model.exists(addr) ? mem_model[addr] : {8{addr}};
        for (int b = 0; b < `MEM_BURST_LEN; b++) begin
            rng_state = xorshift(rng_state);
            gaps      = rng_state[1:0];
            repeat (gaps) begin
                @(posedge clk);
                #1;
            end
            burst_rdata = cur_line[b*`MEM_BEAT_WIDTH +: `MEM_BEAT_WIDTH];
            if (is_write) begin
                cur_line[b*`MEM_BEAT_WIDTH +: `MEM_BEAT_WIDTH] = burst_wdata;
            end
            burst_resp = 1'b1;
            @(posedge clk);
            #1;
            burst_resp = 1'b0;
        end
        if (is_write) begin
            mem_model[addr] = cur_line;
        end
    endtask

    initial begin
        burst_rdata = '0;
        burst_resp  = 1'b0;
        rng_state   = 32'd20260;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && (burst_read || burst_write)) begin
                serve_burst();
            end
        end
    end

    initial begin
        rst           = 1'b1;
        instr_address = '0;
        instr_wdata   = '0;
        instr_read    = 1'b0;
        instr_write   = 1'b0;
        data_address  = '0;
        data_wdata    = '0;
        data_read     = 1'b0;
        data_write    = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // quiet cycles before the first request
        repeat (3) @(posedge clk);
        #1;
        for (int k = 0; k < NUM_STEPS; k++) begin
            fork
                drive_instr(step_iop[k], step_iaddr[k], step_iwdata[k]);
                drive_data(step_dop[k], step_daddr[k], step_dwdata[k]);
            join
            // one cycle with both strobes low
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        $display("errors: data=%0d protocol=%0d", data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // cycle limit against a missing response
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, a response never arrived", cycles);
            $display("errors: data=%0d protocol=%0d", data_errors, proto_errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

endmodule : tb_mem_subsystem

// ==== vlog.f ====
+incdir+common
common/mem_types.sv
arbiter/arbiter.sv
cacheline_adaptor/cacheline_adaptor.sv
rtl/mem_subsystem.sv
bench/mem_checker.sv
bench/tb_mem_subsystem.sv
